//--- verilog/tpu_data_pkg.sv
`default_nettype none

package tpu_data_pkg;

    // array geometry
    localparam int ARRAY_DIM = 4;
    localparam int OPERAND_W = 8;
    localparam int ACC_W     = 32;

    // one signed operand
    typedef logic signed [OPERAND_W-1:0] operand_t;

    // lane 0 sits in the top byte
    // used for A and B buffer words and for the array edges
    typedef operand_t [0:ARRAY_DIM-1] lane_vec_t;

    typedef logic signed [ACC_W-1:0] acc_t;

    // column 0 in the top word, one C row
    typedef acc_t [0:ARRAY_DIM-1] acc_row_t;

endpackage

`default_nettype wire

//--- verilog/tpu_ctrl_pkg.sv
`default_nettype none

package tpu_ctrl_pkg;

    localparam int ADDR_W = 12; // buffer index width
    localparam int DIM_W  = 8;  // width of k, m and n

    // job dimensions, captured on start
    typedef struct packed {
        logic [DIM_W-1:0] k;
        logic [DIM_W-1:0] m;
        logic [DIM_W-1:0] n;
    } job_dims_t;

    // sequencer phase
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0, // clear accumulators and skew lines
        PH_READ  = 2'd1, // stream operands, accumulate
        PH_WRITE = 2'd2  // drain tile rows to C
    } phase_e;

    // one row write into buffer C
    typedef struct packed {
        logic                   wr_en;
        logic [ADDR_W-1:0]      index;
        tpu_data_pkg::acc_row_t data;
    } c_write_t;

endpackage

`default_nettype wire

//--- verilog/operand_skew.sv
`timescale 1ns/1ps
`default_nettype none

module operand_skew (
    input  logic                    clk,
    input  logic                    rst_n,
    input  tpu_ctrl_pkg::phase_e    phase,
    input  logic                    feed_valid,
    input  tpu_data_pkg::lane_vec_t a_data,
    input  tpu_data_pkg::lane_vec_t b_data,
    output wire tpu_data_pkg::lane_vec_t west_edge,
    output wire tpu_data_pkg::lane_vec_t north_edge
);

    // lane i holds i+1 stages, so the wavefront leans one cycle per lane
    for (genvar i = 0; i < tpu_data_pkg::ARRAY_DIM; i++) begin : g_lane
        tpu_data_pkg::operand_t a_line [i+1];
        tpu_data_pkg::operand_t b_line [i+1];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int j = 0; j <= i; j++) begin
                    a_line[j] <= '0;
                    b_line[j] <= '0;
                end
            end else if (phase == tpu_ctrl_pkg::PH_IDLE) begin
                for (int j = 0; j <= i; j++) begin
                    a_line[j] <= '0;
                    b_line[j] <= '0;
                end
            end else if (phase == tpu_ctrl_pkg::PH_READ) begin
                a_line[0] <= feed_valid ? a_data[i] : '0; // zeros once reads stop
                b_line[0] <= feed_valid ? b_data[i] : '0;
                for (int j = 1; j <= i; j++) begin
                    a_line[j] <= a_line[j-1];
                    b_line[j] <= b_line[j-1];
                end
            end
        end

        assign west_edge[i]  = a_line[i]; // row i of the array
        assign north_edge[i] = b_line[i]; // column i of the array
    end

endmodule

`default_nettype wire

//--- verilog/mac_pe.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pe (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tpu_ctrl_pkg::phase_e   phase,
    input  tpu_data_pkg::operand_t west_in,
    input  tpu_data_pkg::operand_t north_in,
    output tpu_data_pkg::operand_t east_out,
    output tpu_data_pkg::operand_t south_out,
    output tpu_data_pkg::acc_t     acc
);

    tpu_data_pkg::acc_t product;

    // both operands sign extend before the multiply
    assign product = tpu_data_pkg::acc_t'(west_in) * tpu_data_pkg::acc_t'(north_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            east_out  <= '0;
            south_out <= '0;
        end else if (phase == tpu_ctrl_pkg::PH_READ) begin
            acc       <= acc + product; // wraps mod 2^32
            east_out  <= west_in;
            south_out <= north_in;
        end else if (phase == tpu_ctrl_pkg::PH_IDLE) begin
            // fresh tile, nothing stale may reach the next PE
            acc       <= '0;
            east_out  <= '0;
            south_out <= '0;
        end
        // PH_WRITE holds everything for the drain
    end

endmodule

`default_nettype wire

//--- verilog/result_drain.sv
`timescale 1ns/1ps
`default_nettype none

module result_drain (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   job_start,
    input  logic                   drain_en,
    input  tpu_data_pkg::acc_row_t [0:tpu_data_pkg::ARRAY_DIM-1] acc_rows,
    output tpu_ctrl_pkg::c_write_t c_write
);

    logic [$clog2(tpu_data_pkg::ARRAY_DIM)-1:0] row_q;
    logic [tpu_ctrl_pkg::ADDR_W-1:0]            c_index_q;

    // row pointer, back to row 0 between tiles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q <= '0;
        end else if (drain_en) begin
            row_q <= row_q + 1'b1;
        end else begin
            row_q <= '0;
        end
    end

    // C words are packed back to back across the whole job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_index_q <= '0;
        end else if (job_start) begin
            c_index_q <= '0;
        end else if (drain_en) begin
            c_index_q <= c_index_q + 1'b1;
        end
    end

    always_comb begin
        c_write.wr_en = drain_en;
        c_write.index = c_index_q;
        c_write.data  = acc_rows[row_q]; // accumulators hold during PH_WRITE
    end

endmodule

`default_nettype wire

//--- verilog/tile_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  tpu_ctrl_pkg::job_dims_t         dims,
    output logic                            busy,
    output logic                            job_start,
    output tpu_ctrl_pkg::phase_e            phase,
    output logic                            feed_valid,
    output logic                            drain_en,
    output logic [tpu_ctrl_pkg::ADDR_W-1:0] a_index,
    output logic [tpu_ctrl_pkg::ADDR_W-1:0] b_index
);

    tpu_ctrl_pkg::job_dims_t          dims_q;
    logic [tpu_ctrl_pkg::DIM_W:0]     step_q;   // one spare bit for k+7
    logic [tpu_ctrl_pkg::DIM_W-1:0]   blk_a_q;
    logic [tpu_ctrl_pkg::DIM_W-1:0]   blk_b_q;
    logic [tpu_ctrl_pkg::ADDR_W-1:0]  a_base_q; // blk_a * k
    logic [tpu_ctrl_pkg::ADDR_W-1:0]  b_base_q; // blk_b * k
    logic [tpu_ctrl_pkg::DIM_W-1:0]   a_blocks;
    logic [tpu_ctrl_pkg::DIM_W-1:0]   b_blocks;
    logic                             last_a;
    logic                             last_b;
    logic [2:0]                       tile_rows;
    logic                             start;
    logic                             read_issue;
    logic                             read_done;
    logic                             write_done;

    assign start     = in_valid && !busy; // strobe ignored mid-job
    assign job_start = start;

    // block counts, rounded up
    assign a_blocks = (dims_q.m >> 2) + tpu_ctrl_pkg::DIM_W'(dims_q.m[1:0] != 2'b00);
    assign b_blocks = (dims_q.n >> 2) + tpu_ctrl_pkg::DIM_W'(dims_q.n[1:0] != 2'b00);
    assign last_a   = (blk_a_q + 1'b1) >= a_blocks;
    assign last_b   = (blk_b_q + 1'b1) >= b_blocks;

    // last A block may be short
    assign tile_rows = (last_a && dims_q.m[1:0] != 2'b00) ? {1'b0, dims_q.m[1:0]} : 3'd4;

    assign read_issue = (phase == tpu_ctrl_pkg::PH_READ) && (step_q < {1'b0, dims_q.k});

    // K reads plus the skew and array fill, PE(3,3) sees its last step at k+7
    assign read_done = (phase == tpu_ctrl_pkg::PH_READ)
        && (step_q == {1'b0, dims_q.k}
            + (tpu_ctrl_pkg::DIM_W+1)'(2 * tpu_data_pkg::ARRAY_DIM - 1));
    assign write_done = (phase == tpu_ctrl_pkg::PH_WRITE)
        && (step_q == (tpu_ctrl_pkg::DIM_W+1)'(tile_rows - 3'd1));

    assign drain_en = (phase == tpu_ctrl_pkg::PH_WRITE);

    assign a_index = read_issue ? a_base_q + tpu_ctrl_pkg::ADDR_W'(step_q) : '0;
    assign b_index = read_issue ? b_base_q + tpu_ctrl_pkg::ADDR_W'(step_q) : '0;

    always_ff @(posedge clk) begin
        if (start) begin
            dims_q <= dims;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            phase      <= tpu_ctrl_pkg::PH_IDLE;
            feed_valid <= 1'b0;
            step_q     <= '0;
            blk_a_q    <= '0;
            blk_b_q    <= '0;
            a_base_q   <= '0;
            b_base_q   <= '0;
        end else begin
            feed_valid <= read_issue; // data returns one cycle after the index
            case (phase)
                tpu_ctrl_pkg::PH_IDLE: begin
                    step_q <= '0;
                    if (start) begin
                        busy     <= 1'b1;
                        blk_a_q  <= '0;
                        blk_b_q  <= '0;
                        a_base_q <= '0;
                        b_base_q <= '0;
                    end else if (busy) begin
                        phase <= tpu_ctrl_pkg::PH_READ;
                    end
                end
                tpu_ctrl_pkg::PH_READ: begin
                    if (read_done) begin
                        phase  <= tpu_ctrl_pkg::PH_WRITE;
                        step_q <= '0;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                tpu_ctrl_pkg::PH_WRITE: begin
                    if (write_done) begin
                        phase  <= tpu_ctrl_pkg::PH_IDLE;
                        step_q <= '0;
                        if (last_a) begin
                            // A blocks wrap, next B block
                            blk_a_q  <= '0;
                            a_base_q <= '0;
                            if (last_b) begin
                                busy <= 1'b0;
                            end else begin
                                blk_b_q  <= blk_b_q + 1'b1;
                                b_base_q <= b_base_q + tpu_ctrl_pkg::ADDR_W'(dims_q.k);
                            end
                        end else begin
                            blk_a_q  <= blk_a_q + 1'b1;
                            a_base_q <= a_base_q + tpu_ctrl_pkg::ADDR_W'(dims_q.k);
                        end
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                default: phase <= tpu_ctrl_pkg::PH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/tpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  tpu_ctrl_pkg::job_dims_t         dims,
    input  tpu_data_pkg::lane_vec_t         a_data,
    input  tpu_data_pkg::lane_vec_t         b_data,
    output logic                            busy,
    output logic [tpu_ctrl_pkg::ADDR_W-1:0] a_index,
    output logic [tpu_ctrl_pkg::ADDR_W-1:0] b_index,
    output tpu_ctrl_pkg::c_write_t          c_write
);

    tpu_ctrl_pkg::phase_e    phase;
    logic                    job_start;
    logic                    feed_valid;
    logic                    drain_en;
    tpu_data_pkg::lane_vec_t west_edge;
    tpu_data_pkg::lane_vec_t north_edge;

    // operand chains, h runs east along a row and v runs south down a column
    wire tpu_data_pkg::operand_t h_net [tpu_data_pkg::ARRAY_DIM][tpu_data_pkg::ARRAY_DIM+1];
    wire tpu_data_pkg::operand_t v_net [tpu_data_pkg::ARRAY_DIM+1][tpu_data_pkg::ARRAY_DIM];
    wire tpu_data_pkg::acc_row_t [0:tpu_data_pkg::ARRAY_DIM-1] acc_rows;

    tile_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .dims       (dims),
        .busy       (busy),
        .job_start  (job_start),
        .phase      (phase),
        .feed_valid (feed_valid),
        .drain_en   (drain_en),
        .a_index    (a_index),
        .b_index    (b_index)
    );

    operand_skew u_skew (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .feed_valid (feed_valid),
        .a_data     (a_data),
        .b_data     (b_data),
        .west_edge  (west_edge),
        .north_edge (north_edge)
    );

    for (genvar r = 0; r < tpu_data_pkg::ARRAY_DIM; r++) begin : g_row
        assign h_net[r][0] = west_edge[r];
        assign v_net[0][r] = north_edge[r]; // r doubles as column index here

        for (genvar c = 0; c < tpu_data_pkg::ARRAY_DIM; c++) begin : g_col
            mac_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .phase     (phase),
                .west_in   (h_net[r][c]),
                .north_in  (v_net[r][c]),
                .east_out  (h_net[r][c+1]),
                .south_out (v_net[r+1][c]),
                .acc       (acc_rows[r][c])
            );
        end
    end

    result_drain u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_start (job_start),
        .drain_en  (drain_en),
        .acc_rows  (acc_rows),
        .c_write   (c_write)
    );

endmodule

`default_nettype wire

//--- tests/tpu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   busy,
    input tpu_ctrl_pkg::c_write_t c_write
);

    logic                            had_write;  // a write already seen in this job
    logic [tpu_ctrl_pkg::ADDR_W-1:0] prev_index;
    int                              fail_count = 0; // assertion failures so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            had_write  <= 1'b0;
            prev_index <= '0;
        end else if (!busy) begin
            had_write <= 1'b0; // job boundary
        end else if (c_write.wr_en) begin
            had_write  <= 1'b1;
            prev_index <= c_write.index;
        end
    end

    busy_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !busy)
        else begin
            fail_count++;
            $error("busy high in the first cycle after reset release");
        end

    write_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
        c_write.wr_en |-> busy)
        else begin
            fail_count++;
            $error("C write while not busy");
        end

    index_steps_by_one: assert property (@(posedge clk) disable iff (!rst_n)
        (c_write.wr_en && had_write)
            |-> c_write.index == tpu_ctrl_pkg::ADDR_W'(prev_index + 1'b1))
        else begin
            fail_count++;
            $error("C write index did not follow the previous one");
        end

endmodule

bind tpu_top tpu_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .busy    (busy),
    .c_write (c_write)
);

`default_nettype wire

//--- tests/tpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int DIM          = tpu_data_pkg::ARRAY_DIM;
    localparam int BUF_DEPTH    = 1 << tpu_ctrl_pkg::ADDR_W;
    localparam int MAX_MN       = 16;
    localparam int MAX_K        = 256;
    localparam int FILL_FIXED   = 0;
    localparam int FILL_RANDOM  = 1;
    localparam int FILL_EXTREME = 2;

    // each job is {k, m, n}
    localparam tpu_ctrl_pkg::job_dims_t SINGLE_DIMS  = {8'd4, 8'd4, 8'd4};
    localparam tpu_ctrl_pkg::job_dims_t PARTIAL_DIMS = {8'd3, 8'd5, 8'd6};
    localparam tpu_ctrl_pkg::job_dims_t OUTER_DIMS   = {8'd1, 8'd7, 8'd7};
    localparam tpu_ctrl_pkg::job_dims_t WRAP_DIMS    = {8'd255, 8'd4, 8'd4};
    localparam tpu_ctrl_pkg::job_dims_t FIRST_DIMS   = {8'd6, 8'd8, 8'd4};
    localparam tpu_ctrl_pkg::job_dims_t STRAY_DIMS   = {8'd2, 8'd2, 8'd2};
    localparam tpu_ctrl_pkg::job_dims_t SECOND_DIMS  = {8'd2, 8'd3, 8'd9};
    localparam tpu_ctrl_pkg::job_dims_t CUT_DIMS     = {8'd8, 8'd8, 8'd8};
    localparam tpu_ctrl_pkg::job_dims_t RECOVER_DIMS = {8'd5, 8'd6, 8'd5};

    logic                            clk;
    logic                            rst_n;
    logic                            in_valid;
    tpu_ctrl_pkg::job_dims_t         dims;
    tpu_data_pkg::lane_vec_t         a_data;
    tpu_data_pkg::lane_vec_t         b_data;
    logic                            busy;
    logic [tpu_ctrl_pkg::ADDR_W-1:0] a_index;
    logic [tpu_ctrl_pkg::ADDR_W-1:0] b_index;
    tpu_ctrl_pkg::c_write_t          c_write;

    tpu_data_pkg::lane_vec_t a_mem [BUF_DEPTH];
    tpu_data_pkg::lane_vec_t b_mem [BUF_DEPTH];
    tpu_data_pkg::operand_t  a_mat [MAX_MN][MAX_K]; // A[row][k]
    tpu_data_pkg::operand_t  b_mat [MAX_K][MAX_MN]; // B[k][col]
    logic [tpu_ctrl_pkg::ADDR_W-1:0] a_rd_idx;
    logic [tpu_ctrl_pkg::ADDR_W-1:0] b_rd_idx;

    tpu_data_pkg::acc_row_t          exp_q  [$];
    tpu_data_pkg::acc_row_t          data_q [$]; // C write stream, in order
    logic [tpu_ctrl_pkg::ADDR_W-1:0] idx_q  [$];
    int                              value_errs;
    int                              other_errs;
    int                              assert_errs;

    tpu_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .dims     (dims),
        .a_data   (a_data),
        .b_data   (b_data),
        .busy     (busy),
        .a_index  (a_index),
        .b_index  (b_index),
        .c_write  (c_write)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // synchronous read buffers, data sampled one cycle after the index
    always @(negedge clk) begin
        a_data   <= a_mem[a_rd_idx];
        b_data   <= b_mem[b_rd_idx];
        a_rd_idx <= a_index;
        b_rd_idx <= b_index;
    end

    always @(negedge clk) begin
        if (rst_n && c_write.wr_en) begin
            idx_q.push_back(c_write.index);
            data_q.push_back(c_write.data);
        end
    end

    function automatic int job_cycles(input tpu_ctrl_pkg::job_dims_t d);
        int a_blocks;
        int b_blocks;
        a_blocks = (int'(d.m) + DIM - 1) / DIM;
        b_blocks = (int'(d.n) + DIM - 1) / DIM;
        // k+8 read cycles, 1 idle, plus one write per row
        return b_blocks * (a_blocks * (int'(d.k) + 9) + int'(d.m));
    endfunction

    function automatic tpu_data_pkg::lane_vec_t background(input int addr);
        logic [tpu_ctrl_pkg::ADDR_W-1:0] a12;
        a12 = addr[tpu_ctrl_pkg::ADDR_W-1:0];
        return {4'h5, a12, 4'ha, a12}; // never read by a correct job
    endfunction

    task automatic compare_row(input string name, input tpu_data_pkg::acc_row_t exp_row,
                               input tpu_data_pkg::acc_row_t act_row);
        if (act_row !== exp_row) begin
            value_errs++;
            $display("error %s: expected %h actual %h", name, exp_row, act_row);
        end
    endtask

    task automatic compare_index(input string name,
                                 input logic [tpu_ctrl_pkg::ADDR_W-1:0] exp_idx,
                                 input logic [tpu_ctrl_pkg::ADDR_W-1:0] act_idx);
        if (act_idx !== exp_idx) begin
            value_errs++;
            $display("error %s: expected index %0d actual %0d", name, exp_idx, act_idx);
        end
    endtask

    task automatic fill_matrices(input int mode);
        for (int i = 0; i < MAX_MN; i++) begin
            for (int kk = 0; kk < MAX_K; kk++) begin
                case (mode)
                    FILL_FIXED: begin
                        a_mat[i][kk] = tpu_data_pkg::operand_t'(i * 5 - kk * 3 + 1);
                        b_mat[kk][i] = tpu_data_pkg::operand_t'(kk * 7 - i * 2 - 4);
                    end
                    FILL_EXTREME: begin // only the two ends of the range
                        a_mat[i][kk] = ((i + kk) % 2 == 0) ? tpu_data_pkg::operand_t'(127)
                                                           : tpu_data_pkg::operand_t'(-128);
                        b_mat[kk][i] = ((i + kk) % 3 == 0) ? tpu_data_pkg::operand_t'(-128)
                                                           : tpu_data_pkg::operand_t'(127);
                    end
                    default: begin
                        a_mat[i][kk] = tpu_data_pkg::operand_t'($urandom);
                        b_mat[kk][i] = tpu_data_pkg::operand_t'($urandom);
                    end
                endcase
            end
        end
    endtask

    // buffer layouts plus the expected C stream for one job
    task automatic prepare_job(input tpu_ctrl_pkg::job_dims_t d);
        int                      k_i;
        int                      m_i;
        int                      n_i;
        int                      rows;
        int                      prod;
        tpu_data_pkg::lane_vec_t word;
        tpu_data_pkg::acc_row_t  c_row;
        k_i = d.k;
        m_i = d.m;
        n_i = d.n;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            a_mem[i] = background(i);
            b_mem[i] = ~background(i);
        end
        for (int blk = 0; blk * DIM < MAX_MN; blk++) begin
            for (int kk = 0; kk < k_i; kk++) begin
                for (int l = 0; l < DIM; l++) begin
                    word[l] = (blk * DIM + l < m_i) ? a_mat[blk * DIM + l][kk] : '0;
                end
                if (blk * DIM < m_i) a_mem[blk * k_i + kk] = word;
                for (int l = 0; l < DIM; l++) begin
                    word[l] = (blk * DIM + l < n_i) ? b_mat[kk][blk * DIM + l] : '0;
                end
                if (blk * DIM < n_i) b_mem[blk * k_i + kk] = word;
            end
        end
        exp_q.delete();
        for (int bb = 0; bb * DIM < n_i; bb++) begin // B blocks outer
            for (int ba = 0; ba * DIM < m_i; ba++) begin
                rows = (m_i - ba * DIM < DIM) ? m_i - ba * DIM : DIM;
                for (int r = 0; r < rows; r++) begin
                    for (int c = 0; c < DIM; c++) begin
                        c_row[c] = '0;
                        for (int kk = 0; kk < k_i && bb * DIM + c < n_i; kk++) begin
                            prod = int'(a_mat[ba * DIM + r][kk]) * int'(b_mat[kk][bb * DIM + c]);
                            c_row[c] = c_row[c] + tpu_data_pkg::acc_t'(prod);
                        end
                    end
                    exp_q.push_back(c_row);
                end
            end
        end
    endtask

    task automatic start_job(input string name, input tpu_ctrl_pkg::job_dims_t d);
        idx_q.delete();
        data_q.delete();
        @(negedge clk);
        dims     = d;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        if (!busy) begin
            other_errs++;
            $display("%s: busy did not rise in the cycle after the start strobe", name);
        end
    endtask

    task automatic finish_job(input string name, input tpu_ctrl_pkg::job_dims_t d);
        int limit;
        int waited;
        limit  = 2 * job_cycles(d) + 8;
        waited = 0;
        while (busy && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            other_errs++;
            $display("%s: busy still high after %0d cycles", name, limit);
        end else begin
            if (idx_q.size() != exp_q.size()) begin
                other_errs++;
                $display("%s: expected %0d C writes but saw %0d", name, exp_q.size(),
                         idx_q.size());
            end
            for (int i = 0; i < idx_q.size() && i < exp_q.size(); i++) begin
                compare_index(name, tpu_ctrl_pkg::ADDR_W'(i), idx_q[i]);
                compare_row(name, exp_q[i], data_q[i]);
            end
        end
    endtask

    task automatic run_job(input string name, input tpu_ctrl_pkg::job_dims_t d);
        prepare_job(d);
        start_job(name, d);
        finish_job(name, d);
    endtask

    task automatic test_start_handling();
        fill_matrices(FILL_RANDOM);
        prepare_job(FIRST_DIMS);
        start_job("start_ignored", FIRST_DIMS);
        repeat (3) @(negedge clk);
        dims     = STRAY_DIMS; // strobe while busy, must be dropped
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        finish_job("start_ignored", FIRST_DIMS);
        fill_matrices(FILL_RANDOM);
        run_job("start_again", SECOND_DIMS);
    endtask

    task automatic test_reset_mid_job();
        int waited;
        fill_matrices(FILL_RANDOM);
        prepare_job(CUT_DIMS);
        start_job("reset_mid_job", CUT_DIMS);
        waited = 0;
        while (!c_write.wr_en && waited < 2 * job_cycles(CUT_DIMS)) begin
            @(negedge clk);
            waited++;
        end
        if (!c_write.wr_en) begin
            other_errs++;
            $display("reset_mid_job: no C write seen before the reset point");
        end
        rst_n = 1'b0;
        #1;
        if (busy || c_write.wr_en) begin
            other_errs++;
            $display("reset_mid_job: busy or wr_en stayed high after reset was asserted");
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        fill_matrices(FILL_RANDOM);
        run_job("after_reset", RECOVER_DIMS);
    endtask

    initial begin
        void'($urandom(32'haeb8_3619));
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        dims       = '0;
        a_data     = '0;
        b_data     = '0;
        a_rd_idx   = '0;
        b_rd_idx   = '0;
        value_errs = 0;
        other_errs = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        fill_matrices(FILL_FIXED);
        run_job("single_tile", SINGLE_DIMS);
        fill_matrices(FILL_RANDOM);
        run_job("partial_blocks", PARTIAL_DIMS);
        fill_matrices(FILL_RANDOM);
        run_job("minimal_depth", OUTER_DIMS);
        fill_matrices(FILL_EXTREME);
        run_job("signed_wrap", WRAP_DIMS);
        test_start_handling();
        test_reset_mid_job();

        repeat (2) @(negedge clk);
        assert_errs = u_dut.u_props.fail_count;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int budget;
        budget = RESET_CYCLES + 2 * (job_cycles(SINGLE_DIMS) + job_cycles(PARTIAL_DIMS)
            + job_cycles(OUTER_DIMS) + job_cycles(WRAP_DIMS) + job_cycles(FIRST_DIMS)
            + job_cycles(SECOND_DIMS) + job_cycles(CUT_DIMS) + job_cycles(RECOVER_DIMS));
        #(budget * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", budget);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/tpu_data_pkg.sv
verilog/tpu_ctrl_pkg.sv
verilog/operand_skew.sv
verilog/mac_pe.sv
verilog/result_drain.sv
verilog/tile_sequencer.sv
verilog/tpu_top.sv
tests/tpu_properties.sv
tests/tpu_tb.sv

//--- Bender.yml
package:
  name: tpu_systolic

sources:
  - files:
      - verilog/tpu_data_pkg.sv
      - verilog/tpu_ctrl_pkg.sv
      - verilog/operand_skew.sv
      - verilog/mac_pe.sv
      - verilog/result_drain.sv
      - verilog/tile_sequencer.sv
      - verilog/tpu_top.sv
  - target: test
    files:
      - tests/tpu_properties.sv
      - tests/tpu_tb.sv
